/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fp_decode
DUT_TOP   ?= fp_decode_top
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(DUT_TOP)

clean:
	rm -rf $(OBJ_DIR)

/* bench/fp_decode_stim.txt */
// cmd_insn_fpusel_rm_store_load_flags; flags = {memread,memwrite,regwrite,fpusrc} then illegal
// cmd 0 idle+push, 1 flush, 2 gap 1, 3 one bubble, 4 burst, 5 into empty queue, F end
5_003100D3_00_0_0_0_20
0_08629253_01_1_0_0_20
0_109423D3_02_2_0_0_20
0_18C5B553_03_3_0_0_20
0_580746D3_04_4_0_0_20
0_203100D3_05_0_0_0_20
0_203110D3_06_0_0_0_20
0_203120D3_07_0_0_0_20
0_283100D3_09_0_0_0_20
0_283110D3_08_0_0_0_20
0_A03100D3_0C_0_0_0_20
0_A03110D3_0B_0_0_0_20
0_A03120D3_0A_0_0_0_20
0_C00110D3_14_1_0_0_20
0_C01110D3_15_1_0_0_20
0_D00100D3_16_0_0_0_20
0_D01100D3_17_0_0_0_20
0_E00100D3_0D_0_0_0_20
0_E00110D3_0E_0_0_0_20
0_F00100D3_0F_0_0_0_20
0_203100C3_10_0_0_0_30
0_203120C7_11_2_0_0_30
0_203100CB_12_0_0_0_30
0_203100CF_13_0_0_0_30
0_00812287_1F_0_0_1_B0
0_00612627_1F_0_1_0_50
// illegal encodings
0_00811287_1F_0_0_0_01
0_483100D3_1F_0_0_0_01
0_581746D3_1F_0_0_0_01
0_003100B3_1F_0_0_0_01
// load-use pairs
0_00012407_1F_0_0_1_B0
3_001404D3_00_0_0_0_20
0_00012507_1F_0_0_1_B0
2_002085D3_00_0_0_0_20
0_00012607_1F_0_0_1_B0
3_602086C3_10_0_0_0_30
0_00012707_1F_0_0_1_B0
3_00E12027_1F_0_1_0_50
0_00012787_1F_0_0_1_B0
2_D00780D3_16_0_0_0_20
// flush with work still queued
4_00012087_1F_0_0_1_B0
4_00108153_00_0_0_0_20
4_102101D3_02_0_0_0_20
4_08318253_01_0_0_0_20
1_00000000_00_0_0_0_00
0_003100D3_00_0_0_0_20
// burst of dependent pairs fills the queue
4_00012087_1F_0_0_1_B0
4_001088D3_00_0_0_0_20
4_00012107_1F_0_0_1_B0
4_00210953_00_0_0_0_20
4_00012187_1F_0_0_1_B0
4_003189D3_00_0_0_0_20
4_00012207_1F_0_0_1_B0
4_00420A53_00_0_0_0_20
4_00012287_1F_0_0_1_B0
4_00528AD3_00_0_0_0_20
4_00012307_1F_0_0_1_B0
4_00630B53_00_0_0_0_20
4_00012387_1F_0_0_1_B0
4_00738BD3_00_0_0_0_20
4_00012407_1F_0_0_1_B0
4_00840C53_00_0_0_0_20
F_00000000_00_0_0_0_00

/* bench/tb_fp_decode.sv */
`timescale 1ns/1ps

module tb_fp_decode import fp_decode_pkg::*; ();

  localparam int MAX_RECS    = 128;
  localparam int CLK_HALF    = 10;   // 20 ns period
  localparam int DRIVE_DLY   = 2;    // inputs change after the edge
  localparam int QUEUE_DEPTH = 4;

  logic     clk = 1'b0;
  logic     rst_n;
  logic     push;
  insn_t    insn;
  logic     flush;
  logic     full;
  logic     out_valid;
  reg_idx_t out_rd;
  fpusel_t  fpusel_s;
  rm_t      rm;
  memctl_t  storecntrl;
  memctl_t  loadcntrl;
  logic     memread;
  logic     memwrite;
  logic     regwrite;
  logic     fpusrc;
  logic     illegal_ins;

  // record fields cmd | insn | fpusel | rm | store | load | {rd,wr,rw,src} illegal
  logic [63:0] stim [MAX_RECS];
  logic [63:0] exp_q [$];   // scoreboard in push order
  int          cyc_q [$];   // cycle of each push
  int          cycle     = 0;
  int          last_out  = -1;
  int          num_recs  = 0;
  logic        full_seen = 1'b0;
  logic        loaded    = 1'b0;
  logic [31:0] rng       = 32'he8ff_6822;

  fp_decode_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_fp_decode_top (
    .clk(clk), .rst_n(rst_n), .push(push), .insn(insn), .flush(flush),
    .full(full), .out_valid(out_valid), .out_rd(out_rd), .fpusel_s(fpusel_s),
    .rm(rm), .storecntrl(storecntrl), .loadcntrl(loadcntrl), .memread(memread),
    .memwrite(memwrite), .regwrite(regwrite), .fpusrc(fpusrc),
    .illegal_ins(illegal_ins)
  );

  always #CLK_HALF clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (full)
      full_seen <= 1'b1;   // burst reached the queue limit
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic fail_run(input string msg);
    $display("Error at %0t: %s", $time, msg);
    $display("Done: errors found");
    $fatal(1, "run stopped");
  endtask

  task automatic check_val(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, actual, expected);
      $display("Done: errors found");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic next_drive_point();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  // called at a drive point, leaves at the next one
  task automatic push_record(input logic [63:0] rec);
    while (full)
      next_drive_point();   // fetch holds off
    push = 1'b1;
    insn = rec[59:28];
    exp_q.push_back(rec);
    cyc_q.push_back(cycle);
    next_drive_point();
    push = 1'b0;
  endtask

  task automatic flush_queue();
    flush = 1'b1;
    next_drive_point();
    flush = 1'b0;
    exp_q.delete();          // queued records are gone
    cyc_q.delete();
    last_out = -1;
  endtask

  task automatic check_output();
    logic [63:0] rec;
    int          pcyc;
    logic [3:0]  cmd;
    if (exp_q.size() == 0) begin
      fail_run("out_valid high with no instruction outstanding");
    end else begin
      rec  = exp_q.pop_front();
      pcyc = cyc_q.pop_front();
      cmd  = rec[63:60];
      check_val("out_rd", 32'(out_rd), 32'(rec[39:35]));   // insn[11:7]
      check_val("fpusel_s", 32'(fpusel_s), 32'(rec[24:20]));
      check_val("rm", 32'(rm), 32'(rec[18:16]));
      check_val("storecntrl", 32'(storecntrl), 32'(rec[13:12]));
      check_val("loadcntrl", 32'(loadcntrl), 32'(rec[9:8]));
      check_val("memread", 32'(memread), 32'(rec[7]));
      check_val("memwrite", 32'(memwrite), 32'(rec[6]));
      check_val("regwrite", 32'(regwrite), 32'(rec[5]));
      check_val("fpusrc", 32'(fpusrc), 32'(rec[4]));
      check_val("illegal_ins", 32'(illegal_ins), 32'(rec[0]));
      // timing classes
      if (cmd == 4'h2)
        check_val("out_valid spacing", cycle - last_out, 1);
      else if (cmd == 4'h3)
        check_val("out_valid spacing", cycle - last_out, 2);   // one bubble
      else if (cmd == 4'h5)
        check_val("push to out_valid latency", cycle - pcyc, 2);
      last_out = cycle;
    end
  endtask

  ////////////////////////////////////////
  // monitor samples mid cycle
  ////////////////////////////////////////
  always @(negedge clk) begin
    if (rst_n) begin
      if (out_valid) begin
        check_output();
      end else begin
        check_val("fpusel_s in bubble", 32'(fpusel_s), 0);
        check_val("rm in bubble", 32'(rm), 0);
        check_val("storecntrl in bubble", 32'(storecntrl), 0);
        check_val("loadcntrl in bubble", 32'(loadcntrl), 0);
        check_val("memread in bubble", 32'(memread), 0);
        check_val("memwrite in bubble", 32'(memwrite), 0);
        check_val("regwrite in bubble", 32'(regwrite), 0);
        check_val("fpusrc in bubble", 32'(fpusrc), 0);
        check_val("illegal_ins in bubble", 32'(illegal_ins), 0);
      end
    end
  end

  // watchdog allows 40 cycles per record
  initial begin
    wait (loaded);
    repeat (num_recs * 40) @(posedge clk);
    fail_run("watchdog expired before all records came out");
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////
  initial begin
    logic [3:0] cmd;
    int         idle;
    rst_n = 1'b0;
    push  = 1'b0;
    flush = 1'b0;
    insn  = '0;
    for (int i = 0; i < MAX_RECS; i++)
      stim[i] = '1;           // reads as end marker
    $readmemh("bench/fp_decode_stim.txt", stim);
    while (num_recs < MAX_RECS && stim[num_recs][63:60] != 4'hf)
      num_recs++;
    if (num_recs == 0)
      fail_run("stimulus file holds no records");
    loaded = 1'b1;

    repeat (4) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    // state right after reset
    check_val("out_valid", 32'(out_valid), 0);
    check_val("fpusel_s", 32'(fpusel_s), 0);
    check_val("rm", 32'(rm), 0);
    check_val("storecntrl", 32'(storecntrl), 0);
    check_val("loadcntrl", 32'(loadcntrl), 0);
    check_val("regwrite", 32'(regwrite), 0);
    check_val("memread", 32'(memread), 0);
    check_val("memwrite", 32'(memwrite), 0);
    check_val("fpusrc", 32'(fpusrc), 0);
    check_val("illegal_ins", 32'(illegal_ins), 0);
    check_val("full", 32'(full), 0);
    check_val("empty", 32'(u_fp_decode_top.empty), 1);

    for (int i = 0; i < num_recs; i++) begin
      cmd = stim[i][63:60];
      case (cmd)
        4'h0: begin                        // push after random idle
          rng  = xorshift32(rng);
          idle = int'(rng[1:0]);
          repeat (idle) next_drive_point();
          push_record(stim[i]);
        end
        4'h1: flush_queue();
        4'h5: begin                        // needs an empty pipe
          while (exp_q.size() != 0)
            next_drive_point();
          next_drive_point();
          push_record(stim[i]);
        end
        default: push_record(stim[i]);     // back to back
      endcase
    end

    while (exp_q.size() != 0)
      @(posedge clk);
    repeat (4) @(posedge clk);             // stray outputs show up here
    if (!full_seen) begin
      fail_run("queue never reported full during the burst");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

/* common/fp_decode_pkg.sv */
package fp_decode_pkg;

  ////////////////////////////////////////
  // field widths
  ////////////////////////////////////////
  typedef logic [31:0] insn_t;    // raw instruction word
  typedef logic [6:0]  opcode_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [2:0]  rm_t;      // rounding mode, also funct3
  typedef logic [4:0]  fpusel_t;  // fpu op select
  typedef logic [1:0]  memctl_t;  // load/store width

  localparam memctl_t MEM_NONE = 2'b00;
  localparam memctl_t MEM_WORD = 2'b01;  // single precision word

  ////////////////////////////////////////
  // fpu select codes
  ////////////////////////////////////////
  localparam fpusel_t FPU_ADD     = 5'b00000;
  localparam fpusel_t FPU_SUB     = 5'b00001;
  localparam fpusel_t FPU_MUL     = 5'b00010;
  localparam fpusel_t FPU_DIV     = 5'b00011;
  localparam fpusel_t FPU_SQRT    = 5'b00100;
  localparam fpusel_t FPU_SGNJ    = 5'b00101;
  localparam fpusel_t FPU_SGNJN   = 5'b00110;
  localparam fpusel_t FPU_SGNJX   = 5'b00111;
  localparam fpusel_t FPU_MAX     = 5'b01000;
  localparam fpusel_t FPU_MIN     = 5'b01001;
  localparam fpusel_t FPU_EQ      = 5'b01010;
  localparam fpusel_t FPU_LT      = 5'b01011;
  localparam fpusel_t FPU_LE      = 5'b01100;
  localparam fpusel_t FPU_MV_XW   = 5'b01101;  // fp bits to int reg
  localparam fpusel_t FPU_CLASS   = 5'b01110;
  localparam fpusel_t FPU_MV_WX   = 5'b01111;  // int bits to fp reg
  localparam fpusel_t FPU_MADD    = 5'b10000;
  localparam fpusel_t FPU_MSUB    = 5'b10001;
  localparam fpusel_t FPU_NMSUB   = 5'b10010;
  localparam fpusel_t FPU_NMADD   = 5'b10011;
  localparam fpusel_t FPU_CVT_WS  = 5'b10100;
  localparam fpusel_t FPU_CVT_WUS = 5'b10101;
  localparam fpusel_t FPU_CVT_SW  = 5'b10110;
  localparam fpusel_t FPU_CVT_SWU = 5'b10111;
  localparam fpusel_t FPU_NONE    = 5'b11111;  // no fpu op

  // major opcodes
  localparam opcode_t OP_FLW   = 7'b0000111;
  localparam opcode_t OP_FSW   = 7'b0100111;
  localparam opcode_t OP_FP    = 7'b1010011;
  localparam opcode_t OP_FMADD = 7'b1000011;  // bits 3..2 pick the fused variant

endpackage

/* design/fp_decode_top.sv */
`timescale 1ns/1ps

module fp_decode_top import fp_decode_pkg::*; #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push,
  input  insn_t    insn,
  input  logic     flush,
  output logic     full,
  output logic     out_valid,
  output reg_idx_t out_rd,
  output fpusel_t  fpusel_s,
  output rm_t      rm,
  output memctl_t  storecntrl,
  output memctl_t  loadcntrl,
  output logic     memread,
  output logic     memwrite,
  output logic     regwrite,
  output logic     fpusrc,
  output logic     illegal_ins
);

  insn_t   head;
  logic    empty;
  logic    hazard;
  logic    advance;
  // decoder outputs, decode side
  fpusel_t id_fpusel_s;
  memctl_t id_storecntrl;
  memctl_t id_loadcntrl;
  rm_t     id_rm;
  logic    id_memread;
  logic    id_memwrite;
  logic    id_regwrite;
  logic    id_fpusrc;
  logic    id_illegal_ins;

  ////////////////////////////////////////
  // queue, decoder, hazard, register
  ////////////////////////////////////////
  fp_insn_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
    .clk(clk), .rst_n(rst_n), .flush(flush), .push(push), .insn(insn),
    .pop(advance), .head(head), .empty(empty), .full(full)
  );

  fp_control u_control (
    .opcode(head[6:0]), .funct3(head[14:12]), .funct7(head[31:25]),
    .rs2(head[24:20]), .ins_zero(empty), .flush(flush), .hazard(hazard),
    .fpusel_s(id_fpusel_s), .storecntrl(id_storecntrl), .loadcntrl(id_loadcntrl),
    .rm(id_rm), .memread(id_memread), .memwrite(id_memwrite),
    .regwrite(id_regwrite), .fpusrc(id_fpusrc), .illegal_ins(id_illegal_ins)
  );

  fp_hazard_unit u_hazard (
    .head(head), .empty(empty), .ex_rd(out_rd), .ex_memread(memread),
    .ex_valid(out_valid), .hazard(hazard), .advance(advance)
  );

  fp_decode_reg u_ex_reg (
    .clk(clk), .rst_n(rst_n), .flush(flush), .advance(advance), .rd(head[11:7]),
    .fpusel_s(id_fpusel_s), .storecntrl(id_storecntrl), .loadcntrl(id_loadcntrl),
    .rm(id_rm), .memread(id_memread), .memwrite(id_memwrite),
    .regwrite(id_regwrite), .fpusrc(id_fpusrc), .illegal_ins(id_illegal_ins),
    .out_valid(out_valid), .ex_rd(out_rd), .ex_fpusel_s(fpusel_s),
    .ex_storecntrl(storecntrl), .ex_loadcntrl(loadcntrl), .ex_rm(rm),
    .ex_memread(memread), .ex_memwrite(memwrite), .ex_regwrite(regwrite),
    .ex_fpusrc(fpusrc), .ex_illegal_ins(illegal_ins)
  );

endmodule

/* fp_decode/fp_control.sv */
`timescale 1ns/1ps

module fp_control import fp_decode_pkg::*; (
  input  opcode_t  opcode,
  input  rm_t      funct3,
  input  logic [6:0] funct7,
  input  reg_idx_t rs2,
  input  logic     ins_zero,    // queue empty, head is zero
  input  logic     flush,
  input  logic     hazard,
  output fpusel_t  fpusel_s,
  output memctl_t  storecntrl,
  output memctl_t  loadcntrl,
  output rm_t      rm,
  output logic     memread,
  output logic     memwrite,
  output logic     regwrite,
  output logic     fpusrc,
  output logic     illegal_ins
);

  logic stall;
  logic regwrite_raw;   // before stall gating
  logic memwrite_raw;
  logic illegal_raw;

  assign stall = flush || hazard || ins_zero;

  ////////////////////////////////////////
  // main decode
  ////////////////////////////////////////
  always_comb begin
    fpusel_s     = FPU_NONE;
    storecntrl   = MEM_NONE;
    loadcntrl    = MEM_NONE;
    rm           = 3'b000;
    memread      = 1'b0;
    fpusrc       = 1'b0;
    regwrite_raw = 1'b0;
    memwrite_raw = 1'b0;
    illegal_raw  = 1'b0;

    case (opcode)
      OP_FLW: begin
        if (funct3 == 3'b010) begin   // word width only
          loadcntrl    = MEM_WORD;
          memread      = 1'b1;
          regwrite_raw = 1'b1;
          fpusrc       = 1'b1;
        end else begin
          illegal_raw = 1'b1;
        end
      end

      OP_FSW: begin
        if (funct3 == 3'b010) begin
          storecntrl   = MEM_WORD;
          memwrite_raw = 1'b1;
          fpusrc       = 1'b1;
        end else begin
          illegal_raw = 1'b1;
        end
      end

      OP_FP: begin
        case (funct7)
          7'h00: begin fpusel_s = FPU_ADD; rm = funct3; end   // fadd.s
          7'h04: begin fpusel_s = FPU_SUB; rm = funct3; end   // fsub.s
          7'h08: begin fpusel_s = FPU_MUL; rm = funct3; end   // fmul.s
          7'h0c: begin fpusel_s = FPU_DIV; rm = funct3; end   // fdiv.s
          7'h2c: begin
            if (rs2 == '0) begin          // fsqrt.s, rs2 must be zero
              fpusel_s = FPU_SQRT;
              rm       = funct3;
            end else begin
              illegal_raw = 1'b1;
            end
          end
          7'h10: begin                    // sign injection, rm unused
            case (funct3)
              3'b000:  fpusel_s = FPU_SGNJ;
              3'b001:  fpusel_s = FPU_SGNJN;
              3'b010:  fpusel_s = FPU_SGNJX;
              default: illegal_raw = 1'b1;
            endcase
          end
          7'h14: begin
            case (funct3)
              3'b000:  fpusel_s = FPU_MIN;
              3'b001:  fpusel_s = FPU_MAX;
              default: illegal_raw = 1'b1;
            endcase
          end
          7'h50: begin                    // compares write an int reg
            case (funct3)
              3'b000:  fpusel_s = FPU_LE;
              3'b001:  fpusel_s = FPU_LT;
              3'b010:  fpusel_s = FPU_EQ;
              default: illegal_raw = 1'b1;
            endcase
          end
          7'h60: begin                    // float to int
            case (rs2)
              5'd0:    begin fpusel_s = FPU_CVT_WS;  rm = funct3; end
              5'd1:    begin fpusel_s = FPU_CVT_WUS; rm = funct3; end
              default: illegal_raw = 1'b1;
            endcase
          end
          7'h68: begin                    // int to float
            case (rs2)
              5'd0:    begin fpusel_s = FPU_CVT_SW;  rm = funct3; end
              5'd1:    begin fpusel_s = FPU_CVT_SWU; rm = funct3; end
              default: illegal_raw = 1'b1;
            endcase
          end
          7'h70: begin
            if (rs2 == '0 && funct3 == 3'b000)
              fpusel_s = FPU_MV_XW;       // fmv.x.w
            else if (rs2 == '0 && funct3 == 3'b001)
              fpusel_s = FPU_CLASS;       // fclass.s
            else
              illegal_raw = 1'b1;
          end
          7'h78: begin
            if (rs2 == '0 && funct3 == 3'b000)
              fpusel_s = FPU_MV_WX;       // fmv.w.x
            else
              illegal_raw = 1'b1;
          end
          default: illegal_raw = 1'b1;    // unknown funct7
        endcase
        regwrite_raw = !illegal_raw;
      end

      default: begin
        // fused group shares opcode bits 6..4 and 1..0
        if ({opcode[6:4], opcode[1:0]} == {OP_FMADD[6:4], OP_FMADD[1:0]} &&
            funct7[1:0] == 2'b00) begin   // fmt must be single
          case (opcode[3:2])
            2'b00: fpusel_s = FPU_MADD;
            2'b01: fpusel_s = FPU_MSUB;
            2'b10: fpusel_s = FPU_NMSUB;
            2'b11: fpusel_s = FPU_NMADD;
          endcase
          rm           = funct3;
          regwrite_raw = 1'b1;
          fpusrc       = 1'b1;
        end else begin
          illegal_raw = 1'b1;             // not an F-extension opcode
        end
      end
    endcase
  end

  // gating toward the decode register
  assign regwrite    = regwrite_raw && !stall;
  assign memwrite    = memwrite_raw && !stall;
  assign illegal_ins = illegal_raw && !flush && !ins_zero;  // hazard keeps it

endmodule

/* fp_decode/fp_decode_reg.sv */
`timescale 1ns/1ps

module fp_decode_reg import fp_decode_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     flush,
  input  logic     advance,
  input  reg_idx_t rd,
  input  fpusel_t  fpusel_s,
  input  memctl_t  storecntrl,
  input  memctl_t  loadcntrl,
  input  rm_t      rm,
  input  logic     memread,
  input  logic     memwrite,
  input  logic     regwrite,
  input  logic     fpusrc,
  input  logic     illegal_ins,
  output logic     out_valid,
  output reg_idx_t ex_rd,
  output fpusel_t  ex_fpusel_s,
  output memctl_t  ex_storecntrl,
  output memctl_t  ex_loadcntrl,
  output rm_t      ex_rm,
  output logic     ex_memread,
  output logic     ex_memwrite,
  output logic     ex_regwrite,
  output logic     ex_fpusrc,
  output logic     ex_illegal_ins
);

  ////////////////////////////////////////
  // controls clear to a bubble when idle
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n || flush || !advance) begin
      out_valid      <= 1'b0;       // bubble
      ex_fpusel_s    <= '0;
      ex_storecntrl  <= MEM_NONE;
      ex_loadcntrl   <= MEM_NONE;
      ex_rm          <= '0;
      ex_memread     <= 1'b0;
      ex_memwrite    <= 1'b0;
      ex_regwrite    <= 1'b0;
      ex_fpusrc      <= 1'b0;
      ex_illegal_ins <= 1'b0;
    end else begin
      out_valid      <= 1'b1;
      ex_fpusel_s    <= fpusel_s;
      ex_storecntrl  <= storecntrl;
      ex_loadcntrl   <= loadcntrl;
      ex_rm          <= rm;
      ex_memread     <= memread;
      ex_memwrite    <= memwrite;
      ex_regwrite    <= regwrite;
      ex_fpusrc      <= fpusrc;
      ex_illegal_ins <= illegal_ins;
    end
  end

  // rd held through bubbles
  always_ff @(posedge clk) begin
    if (advance) begin
      ex_rd <= rd;
    end
  end

endmodule

/* fp_decode/fp_hazard_unit.sv */
`timescale 1ns/1ps

module fp_hazard_unit import fp_decode_pkg::*; (
  input  insn_t    head,
  input  logic     empty,
  input  reg_idx_t ex_rd,       // rd in decode register
  input  logic     ex_memread,  // that entry is a flw
  input  logic     ex_valid,
  output logic     hazard,
  output logic     advance
);

  opcode_t    opcode;
  logic [6:0] funct7;
  logic       is_fp;
  logic       is_fused;
  logic       uses_rs1;
  logic       uses_rs2;
  logic       uses_rs3;

  assign opcode   = head[6:0];
  assign funct7   = head[31:25];
  assign is_fp    = (opcode == OP_FP);
  assign is_fused = ({opcode[6:4], opcode[1:0]} == {OP_FMADD[6:4], OP_FMADD[1:0]});

  ////////////////////////////////////////
  // which fp sources the head reads
  ////////////////////////////////////////
  // int to float and mv.w.x take rs1 from the int file
  assign uses_rs1 = (is_fp && funct7 != 7'h68 && funct7 != 7'h78) || is_fused;
  assign uses_rs2 = (is_fp && (funct7 == 7'h00 || funct7 == 7'h04 ||
                               funct7 == 7'h08 || funct7 == 7'h0c ||
                               funct7 == 7'h10 || funct7 == 7'h14 ||
                               funct7 == 7'h50))
                    || is_fused
                    || (opcode == OP_FSW);     // store data
  assign uses_rs3 = is_fused;

  // load still in decode register, result not ready for the head
  assign hazard = ex_valid && ex_memread && !empty &&
                  ((uses_rs1 && head[19:15] == ex_rd) ||
                   (uses_rs2 && head[24:20] == ex_rd) ||
                   (uses_rs3 && head[31:27] == ex_rd));

  assign advance = !empty && !hazard;  // pop and load in same edge

endmodule

/* fp_decode/fp_insn_queue.sv */
`timescale 1ns/1ps

module fp_insn_queue import fp_decode_pkg::*; #(
  parameter int QUEUE_DEPTH = 4  // power of two, >= 2
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  flush,
  input  logic  push,
  input  insn_t insn,
  input  logic  pop,
  output insn_t head,
  output logic  empty,
  output logic  full
);

  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  localparam logic [PTR_W:0] FULL_CNT = (PTR_W+1)'(QUEUE_DEPTH);

  insn_t            mem [QUEUE_DEPTH];  // storage, no reset
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;              // occupancy
  logic             do_push;
  logic             do_pop;

  // flush wins over both ends
  assign do_push = push && !full && !flush;   // push while full is dropped
  assign do_pop  = pop && !empty && !flush;

  assign empty = (count == '0);
  assign full  = (count == FULL_CNT);
  assign head  = empty ? '0 : mem[rd_ptr];    // zero when nothing queued

  ////////////////////////////////////////
  // pointers and count
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      // push and pop together leave count alone
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

  // write port
  always_ff @(posedge clk) begin
    if (do_push)
      mem[wr_ptr] <= insn;
  end

endmodule

/* src.f */
common/fp_decode_pkg.sv
fp_decode/fp_insn_queue.sv
fp_decode/fp_control.sv
fp_decode/fp_hazard_unit.sv
fp_decode/fp_decode_reg.sv
design/fp_decode_top.sv
bench/tb_fp_decode.sv
